/* common/im2col_pkg.sv */
package im2col_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int DATA_W = 32;         // Bus word and element
    localparam int STRB_W = DATA_W / 8; // One enable per byte
    localparam int ADDR_W = 16;         // Byte address

    // Buffer depths in words
    localparam int IN_DEPTH  = 1024;
    localparam int OUT_DEPTH = 4096;
    localparam int IN_IDX_W  = 10;
    localparam int OUT_IDX_W = 12;

    ////////////////////
    // Address map
    ////////////////////
    localparam int IN_BASE  = 'h0000;   // Feature map, write only from the bus
    localparam int OUT_BASE = 'h4000;   // Unrolled columns, read only from the bus
    localparam int REG_BASE = 'hC000;   // Register file
    localparam int REG_NUM  = 12;

    // Register word index inside the register region
    typedef enum logic [3:0] {
        RI_C,
        RI_H,
        RI_W,
        RI_KH,
        RI_KW,
        RI_PAD_H,
        RI_PAD_W,
        RI_STRIDE_H,
        RI_STRIDE_W,
        RI_ZEROPOINT,
        RI_CTRL,        // Bit 0 starts the engine
        RI_STATUS       // Bit 0 busy, bit 1 done
    } reg_idx_e;

    // Response codes, AXI encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } bus_resp_e;

    typedef enum logic [1:0] {ENG_IDLE, ENG_RUN, ENG_DRAIN} eng_state_e;

    typedef enum logic [1:0] {RG_IN, RG_OUT, RG_REG, RG_NONE} region_e;

endpackage

/* src/im2col_buffer.sv */
`timescale 1ns/1ps

module im2col_buffer #(
    parameter int DEPTH = im2col_pkg::IN_DEPTH,
    parameter int IDX_W = im2col_pkg::IN_IDX_W
) (
    input  logic                          clk,
    input  logic [IDX_W-1:0]              windex,
    input  logic                          wenable,
    input  logic [im2col_pkg::STRB_W-1:0] wstrb,
    input  logic [im2col_pkg::DATA_W-1:0] wdata,
    input  logic [IDX_W-1:0]              rindex,
    input  logic                          renable,
    output logic [im2col_pkg::DATA_W-1:0] rdata
);
    import im2col_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wenable) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) mem[windex][8*b +: 8] <= wdata[8*b +: 8]; // Byte lane
            end
        end
        if (renable) rdata <= mem[rindex];  // Holds last word otherwise
    end

    // Callers never step past the end of the array
    a_idx_range: assert property (@(posedge clk)
        (wenable |-> int'(windex) < DEPTH) and (renable |-> int'(rindex) < DEPTH));

endmodule

/* src/im2col_bus_slave.sv */
`timescale 1ns/1ps

module im2col_bus_slave (
    input  logic                             clk,
    input  logic                             rstnn,
    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic                             req_write,
    input  logic [im2col_pkg::ADDR_W-1:0]    req_addr,
    input  logic [im2col_pkg::DATA_W-1:0]    req_wdata,
    input  logic [im2col_pkg::STRB_W-1:0]    req_wstrb,
    output logic                             resp_valid,
    input  logic                             resp_ready,
    output logic [im2col_pkg::DATA_W-1:0]    resp_rdata,
    output im2col_pkg::bus_resp_e            resp_code,
    output logic [im2col_pkg::IN_IDX_W-1:0]  ibuf_windex,
    output logic                             ibuf_wenable,
    output logic [im2col_pkg::STRB_W-1:0]    ibuf_wstrb,
    output logic [im2col_pkg::DATA_W-1:0]    ibuf_wdata,
    output logic [im2col_pkg::OUT_IDX_W-1:0] obuf_rindex,
    output logic                             obuf_renable,
    input  logic [im2col_pkg::DATA_W-1:0]    obuf_rdata,
    output im2col_pkg::reg_idx_e             reg_index,
    output logic                             reg_wenable,
    output logic [im2col_pkg::STRB_W-1:0]    reg_wstrb,
    output logic [im2col_pkg::DATA_W-1:0]    reg_wdata,
    output logic                             reg_renable,
    input  logic [im2col_pkg::DATA_W-1:0]    reg_rdata
);
    import im2col_pkg::*;

    logic [ADDR_W-1:0] in_off, out_off, reg_off;
    region_e           region, rd_region;
    logic              accept, outstanding, rd_pending;

    ////////////////////
    // Address decode
    ////////////////////
    // Offsets wrap below each base, so one compare per region is enough
    assign in_off  = req_addr - ADDR_W'(IN_BASE);
    assign out_off = req_addr - ADDR_W'(OUT_BASE);
    assign reg_off = req_addr - ADDR_W'(REG_BASE);

    always_comb begin
        if (in_off < ADDR_W'(IN_DEPTH * 4))        region = RG_IN;
        else if (out_off < ADDR_W'(OUT_DEPTH * 4)) region = RG_OUT;
        else if (reg_off < ADDR_W'(REG_NUM * 4))   region = RG_REG;
        else                                       region = RG_NONE;
    end

    assign req_ready = !outstanding;    // One request in flight
    assign accept    = req_valid && req_ready;

    // Storage strobes, only in the accept cycle
    assign ibuf_windex  = in_off[IN_IDX_W+1:2];
    assign ibuf_wenable = accept && req_write && region == RG_IN;
    assign ibuf_wstrb   = req_wstrb;
    assign ibuf_wdata   = req_wdata;
    assign obuf_rindex  = out_off[OUT_IDX_W+1:2];
    assign obuf_renable = accept && !req_write && region == RG_OUT;
    assign reg_index    = reg_idx_e'(reg_off[5:2]);
    assign reg_wenable  = accept && req_write && region == RG_REG;
    assign reg_wstrb    = req_wstrb;
    assign reg_wdata    = req_wdata;
    assign reg_renable  = accept && !req_write && region == RG_REG;

    ////////////////////
    // Response
    ////////////////////
    always_ff @(posedge clk or negedge rstnn) begin
        if (!rstnn) begin
            outstanding <= 1'b0;
            rd_pending  <= 1'b0;
            rd_region   <= RG_NONE;
            resp_valid  <= 1'b0;
            resp_code   <= RESP_OKAY;
            resp_rdata  <= '0;
        end else begin
            rd_pending <= 1'b0;
            if (accept) begin
                outstanding <= 1'b1;
                if (!req_write && region != RG_NONE) begin // Wait for storage
                    rd_pending <= 1'b1;
                    rd_region  <= region;
                end else begin
                    resp_valid <= 1'b1;
                    resp_rdata <= '0;
                    if (region == RG_NONE)     resp_code <= RESP_DECERR;
                    else if (region == RG_OUT) resp_code <= RESP_SLVERR; // Engine owns it
                    else                       resp_code <= RESP_OKAY;
                end
            end
            if (rd_pending) begin
                resp_valid <= 1'b1;
                resp_code  <= RESP_OKAY;
                case (rd_region)
                    RG_OUT:  resp_rdata <= obuf_rdata;
                    RG_REG:  resp_rdata <= reg_rdata;
                    default: resp_rdata <= '0; // No bus read port on the input buffer
                endcase
            end
            if (resp_valid && resp_ready) begin
                resp_valid  <= 1'b0;
                outstanding <= 1'b0;
            end
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rstnn)
        $onehot0({ibuf_wenable, obuf_renable, reg_wenable, reg_renable}));
    a_resp_hold: assert property (@(posedge clk) disable iff (!rstnn)
        resp_valid && !resp_ready |=> resp_valid);

endmodule

/* src/im2col_regfile.sv */
`timescale 1ns/1ps

module im2col_regfile (
    input  logic                          clk,
    input  logic                          rstnn,
    input  im2col_pkg::reg_idx_e          reg_index,
    input  logic                          reg_wenable,
    input  logic [im2col_pkg::STRB_W-1:0] reg_wstrb,
    input  logic [im2col_pkg::DATA_W-1:0] reg_wdata,
    input  logic                          reg_renable,
    output logic [im2col_pkg::DATA_W-1:0] reg_rdata,
    output logic [im2col_pkg::DATA_W-1:0] c_num,
    output logic [im2col_pkg::DATA_W-1:0] h_in,
    output logic [im2col_pkg::DATA_W-1:0] w_in,
    output logic [im2col_pkg::DATA_W-1:0] k_h,
    output logic [im2col_pkg::DATA_W-1:0] k_w,
    output logic [im2col_pkg::DATA_W-1:0] pad_h,
    output logic [im2col_pkg::DATA_W-1:0] pad_w,
    output logic [im2col_pkg::DATA_W-1:0] stride_h,
    output logic [im2col_pkg::DATA_W-1:0] stride_w,
    output logic [im2col_pkg::DATA_W-1:0] zeropoint,
    output logic                          start,
    input  logic                          busy,
    input  logic                          finish
);
    import im2col_pkg::*;

    logic [DATA_W-1:0] geo [int'(RI_ZEROPOINT) + 1];   // C up to zero point
    logic              done;

    always_ff @(posedge clk or negedge rstnn) begin
        if (!rstnn) begin
            for (int i = 0; i <= int'(RI_ZEROPOINT); i++) begin
                geo[i] <= '0;
            end
            start <= 1'b0;
            done  <= 1'b0;
        end else begin
            if (reg_wenable && reg_index <= RI_ZEROPOINT) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (reg_wstrb[b]) geo[reg_index][8*b +: 8] <= reg_wdata[8*b +: 8];
                end
            end
            // CTRL bit 0, dropped while a run is going
            start <= reg_wenable && reg_index == RI_CTRL && reg_wstrb[0] && reg_wdata[0]
                     && !busy;
            if (start)       done <= 1'b0;
            else if (finish) done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_renable) begin
            if (reg_index <= RI_ZEROPOINT)   reg_rdata <= geo[reg_index];
            else if (reg_index == RI_STATUS) reg_rdata <= {{(DATA_W-2){1'b0}}, done, busy};
            else                             reg_rdata <= '0; // CTRL is a command
        end
    end

    assign c_num     = geo[RI_C];
    assign h_in      = geo[RI_H];
    assign w_in      = geo[RI_W];
    assign k_h       = geo[RI_KH];
    assign k_w       = geo[RI_KW];
    assign pad_h     = geo[RI_PAD_H];
    assign pad_w     = geo[RI_PAD_W];
    assign stride_h  = geo[RI_STRIDE_H];
    assign stride_w  = geo[RI_STRIDE_W];
    assign zeropoint = geo[RI_ZEROPOINT];

    // Engine leaves idle only after a start, so busy lags start by a cycle
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rstnn) start |-> !busy);

endmodule

/* im2col_engine/im2col_engine.sv */
`timescale 1ns/1ps

module im2col_engine (
    input  logic                             clk,
    input  logic                             rstnn,
    input  logic                             start,
    input  logic [im2col_pkg::DATA_W-1:0]    c_num,
    input  logic [im2col_pkg::DATA_W-1:0]    h_in,
    input  logic [im2col_pkg::DATA_W-1:0]    w_in,
    input  logic [im2col_pkg::DATA_W-1:0]    k_h,
    input  logic [im2col_pkg::DATA_W-1:0]    k_w,
    input  logic [im2col_pkg::DATA_W-1:0]    pad_h,
    input  logic [im2col_pkg::DATA_W-1:0]    pad_w,
    input  logic [im2col_pkg::DATA_W-1:0]    stride_h,
    input  logic [im2col_pkg::DATA_W-1:0]    stride_w,
    input  logic [im2col_pkg::DATA_W-1:0]    zeropoint,
    output logic                             busy,
    output logic                             finish,
    output logic [im2col_pkg::IN_IDX_W-1:0]  ibuf_rindex,
    output logic                             ibuf_renable,
    input  logic [im2col_pkg::DATA_W-1:0]    ibuf_rdata,
    output logic [im2col_pkg::OUT_IDX_W-1:0] obuf_windex,
    output logic                             obuf_wenable,
    output logic [im2col_pkg::DATA_W-1:0]    obuf_wdata
);
    import im2col_pkg::*;

    eng_state_e            state;
    logic [DATA_W-1:0]     c, kh, kw;     // Output row counters
    logic [DATA_W-1:0]     ph, pw;        // Window origin in padded coordinates
    logic [DATA_W-1:0]     plane;         // c * H * W as a running sum
    logic [OUT_IDX_W-1:0]  out_idx;
    logic [DATA_W-1:0]     row_p, col_p, in_lin;
    logic                  inb, last_w, last_h, last_kw, last_kh, last_c;
    logic                  wr_v, wr_pad;
    logic [OUT_IDX_W-1:0]  wr_idx;

    ////////////////////
    // Issue decode
    ////////////////////
    assign row_p  = ph + kh;
    assign col_p  = pw + kw;
    assign inb    = row_p >= pad_h && row_p < pad_h + h_in
                    && col_p >= pad_w && col_p < pad_w + w_in;
    assign in_lin = plane + (row_p - pad_h) * w_in + (col_p - pad_w);

    // Next window must still fit inside the padded map
    assign last_w  = pw + stride_w + k_w > w_in + (pad_w << 1);
    assign last_h  = ph + stride_h + k_h > h_in + (pad_h << 1);
    assign last_kw = kw == k_w - 1;
    assign last_kh = kh == k_h - 1;
    assign last_c  = c == c_num - 1;

    assign busy         = state != ENG_IDLE;
    assign finish       = state == ENG_DRAIN;  // Last write lands here
    assign ibuf_rindex  = in_lin[IN_IDX_W-1:0];
    assign ibuf_renable = state == ENG_RUN && inb; // Padding skips the read

    always_ff @(posedge clk or negedge rstnn) begin
        if (!rstnn) begin
            state   <= ENG_IDLE;
            {c, kh, kw, ph, pw, plane} <= '0;
            out_idx <= '0;
            wr_v    <= 1'b0;
        end else begin
            wr_v <= state == ENG_RUN;
            case (state)
                ENG_IDLE: begin
                    if (start) begin
                        {c, kh, kw, ph, pw, plane} <= '0;
                        out_idx <= '0;
                        state   <= ENG_RUN;
                    end
                end
                ENG_RUN: begin
                    out_idx <= out_idx + OUT_IDX_W'(1);
                    if (!last_w) pw <= pw + stride_w;     // ow step
                    else begin
                        pw <= '0;
                        if (!last_h) ph <= ph + stride_h; // oh step
                        else begin
                            ph <= '0;
                            if (!last_kw) kw <= kw + 1;
                            else begin
                                kw <= '0;
                                if (!last_kh) kh <= kh + 1;
                                else begin
                                    kh <= '0;
                                    if (!last_c) begin
                                        c     <= c + 1;
                                        plane <= plane + h_in * w_in;
                                    end else begin
                                        state <= ENG_DRAIN;
                                    end
                                end
                            end
                        end
                    end
                end
                default: state <= ENG_IDLE;   // DRAIN, one cycle
            endcase
        end
    end

    // Write stage, one cycle behind issue
    always_ff @(posedge clk) begin
        wr_pad <= !inb;
        wr_idx <= out_idx;
    end

    assign obuf_wenable = wr_v;
    assign obuf_windex  = wr_idx;
    assign obuf_wdata   = wr_pad ? zeropoint : ibuf_rdata;

    // Last buffer word ends the run, no wrap back to word 0
    a_out_range: assert property (@(posedge clk) disable iff (!rstnn)
        obuf_wenable && obuf_windex == OUT_IDX_W'(OUT_DEPTH - 1) |=> !obuf_wenable);

endmodule

/* src/im2col_top.sv */
`timescale 1ns/1ps

module im2col_top (
    input  logic                          clk,
    input  logic                          rstnn,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          req_write,
    input  logic [im2col_pkg::ADDR_W-1:0] req_addr,
    input  logic [im2col_pkg::DATA_W-1:0] req_wdata,
    input  logic [im2col_pkg::STRB_W-1:0] req_wstrb,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [im2col_pkg::DATA_W-1:0] resp_rdata,
    output im2col_pkg::bus_resp_e         resp_code
);
    import im2col_pkg::*;

    // Bus side of the buffers and registers
    logic [IN_IDX_W-1:0]  ibuf_windex, ibuf_rindex;
    logic                 ibuf_wenable, ibuf_renable;
    logic [STRB_W-1:0]    ibuf_wstrb, reg_wstrb;
    logic [DATA_W-1:0]    ibuf_wdata, ibuf_rdata, obuf_wdata, obuf_rdata;
    logic [OUT_IDX_W-1:0] obuf_windex, obuf_rindex;
    logic                 obuf_wenable, obuf_renable;
    reg_idx_e             reg_index;
    logic                 reg_wenable, reg_renable;
    logic [DATA_W-1:0]    reg_wdata, reg_rdata;
    // Geometry and handshake to the engine
    logic [DATA_W-1:0]    c_num, h_in, w_in, k_h, k_w, pad_h, pad_w;
    logic [DATA_W-1:0]    stride_h, stride_w, zeropoint;
    logic                 start, busy, finish;

    im2col_bus_slave u_bus_slave (.*);

    im2col_buffer #(.DEPTH(IN_DEPTH), .IDX_W(IN_IDX_W)) u_in_buf (
        .clk     (clk),
        .windex  (ibuf_windex),
        .wenable (ibuf_wenable),
        .wstrb   (ibuf_wstrb),
        .wdata   (ibuf_wdata),
        .rindex  (ibuf_rindex),
        .renable (ibuf_renable),
        .rdata   (ibuf_rdata)
    );

    im2col_buffer #(.DEPTH(OUT_DEPTH), .IDX_W(OUT_IDX_W)) u_out_buf (
        .clk     (clk),
        .windex  (obuf_windex),
        .wenable (obuf_wenable),
        .wstrb   ({STRB_W{1'b1}}),   // Engine writes whole words
        .wdata   (obuf_wdata),
        .rindex  (obuf_rindex),
        .renable (obuf_renable),
        .rdata   (obuf_rdata)
    );

    im2col_regfile u_regfile (.*);

    im2col_engine u_engine (.*);

endmodule

/* test/im2col_tb.sv */
`timescale 1ns/1ps

module im2col_tb;
    import im2col_pkg::*;

    logic              clk, rstnn;
    logic              req_valid, req_ready, req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_wstrb;
    logic              resp_valid, resp_ready;
    logic [DATA_W-1:0] resp_rdata;
    bus_resp_e         resp_code;

    logic [31:0]       lfsr;              // Galois LFSR state
    logic              stall_on;          // Random resp_ready stalls
    logic [DATA_W-1:0] model_in [IN_DEPTH];   // Host copy of the feature map
    string             cur_test;
    int                errors, test_errs, checks, tests, failed_tests;
    int                work;              // Cycle budget, grows per run
    int                cycles;

    im2col_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < 2000 + 4 * work) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};                               // One step per bit
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hD000_0001 : lfsr >> 1; // x^32+x^31+x^29+x+1
        end
        return v;
    endfunction

    task automatic check_word(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_resp(input bus_resp_e exp, input bus_resp_e act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %s, actual %s", cur_test, exp.name(), act.name());
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errs) begin
            $display("%s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", cur_test, errors - test_errs);
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic bus_xfer(input logic write, input int addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] rdata,
                            output bus_resp_e code);
        logic taken;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = ADDR_W'(addr);
        req_wdata = wdata;
        req_wstrb = strb;
        while (!req_ready) @(negedge clk);
        @(negedge clk);                   // Accepted on the edge just passed
        req_valid = 1'b0;
        taken     = 1'b0;
        while (!taken) begin
            if (req_ready) begin
                errors++;
                $display("%s: request channel ready while a response is pending", cur_test);
            end
            resp_ready = stall_on ? rand_bits(1) != 0 : 1'b1;
            if (resp_valid && resp_ready) begin
                rdata = resp_rdata;
                code  = resp_code;
                taken = 1'b1;
            end
            @(negedge clk);
        end
        resp_ready = 1'b0;
        if (resp_valid) begin             // Same response offered twice
            errors++;
            $display("%s: response still valid after it was taken", cur_test);
        end
    endtask

    task automatic write_ok(input int addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] rd;
        bus_resp_e         code;
        bus_xfer(1'b1, addr, data, strb, rd, code);
        check_resp(RESP_OKAY, code);
    endtask

    task automatic read_ok(input int addr, output logic [DATA_W-1:0] data);
        bus_resp_e code;
        bus_xfer(1'b0, addr, '0, '0, data, code);
        check_resp(RESP_OKAY, code);
    endtask

    task automatic wait_done(output logic [DATA_W-1:0] status);
        status = '0;
        while (!status[1]) read_ok(REG_BASE + 4 * int'(RI_STATUS), status);
    endtask

    ////////////////////
    // im2col run + model
    ////////////////////
    task automatic run_conv(input int cn, input int h, input int w, input int kh, input int kw,
                            input int ph, input int pw, input int sh, input int sw,
                            input logic [DATA_W-1:0] zp);
        int                geo [10];
        int                oh_n, ow_n, in_n, out_n, ih, iw, idx;
        logic [DATA_W-1:0] rd, exp_v;
        geo   = '{cn, h, w, kh, kw, ph, pw, sh, sw, int'(zp)};
        oh_n  = (h + 2 * ph - kh) / sh + 1;
        ow_n  = (w + 2 * pw - kw) / sw + 1;
        in_n  = cn * h * w;
        out_n = cn * kh * kw * oh_n * ow_n;
        work += 2 * out_n + in_n + 16;    // Engine, readback, loads, registers
        for (int i = 0; i < in_n; i++) begin
            model_in[i] = rand_bits(DATA_W);
            write_ok(IN_BASE + 4 * i, model_in[i], 4'hF);
        end
        for (int i = 0; i < 10; i++) write_ok(REG_BASE + 4 * i, geo[i], 4'hF);
        write_ok(REG_BASE + 4 * int'(RI_CTRL), 1, 4'hF);
        wait_done(rd);
        idx = 0;
        // Row (c, ki, kj), column (oh, ow)
        for (int c = 0; c < cn; c++) begin
            for (int ki = 0; ki < kh; ki++) begin
                for (int kj = 0; kj < kw; kj++) begin
                    for (int oh = 0; oh < oh_n; oh++) begin
                        for (int ow = 0; ow < ow_n; ow++) begin
                            ih = oh * sh + ki - ph;
                            iw = ow * sw + kj - pw;
                            if (ih >= 0 && ih < h && iw >= 0 && iw < w)
                                exp_v = model_in[(c * h + ih) * w + iw];
                            else
                                exp_v = zp;   // Padded position
                            read_ok(OUT_BASE + 4 * idx, rd);
                            check_word(exp_v, rd);
                            idx++;
                        end
                    end
                end
            end
        end
    endtask

    // Redraw until the unrolled matrix fits the output buffer
    task automatic random_conv();
        int g [9];
        int oh_n, ow_n;
        do begin
            g[0] = 1 + int'(rand_bits(2) % 3);    // C
            g[1] = 3 + int'(rand_bits(3));        // H
            g[2] = 3 + int'(rand_bits(3));        // W
            g[3] = 1 + int'(rand_bits(2) % 3);
            g[4] = 1 + int'(rand_bits(2) % 3);
            g[5] = int'(rand_bits(2) % 3);        // Pads 0..2
            g[6] = int'(rand_bits(2) % 3);
            g[7] = 1 + int'(rand_bits(2) % 3);    // Strides 1..3
            g[8] = 1 + int'(rand_bits(2) % 3);
            oh_n = (g[1] + 2 * g[5] - g[3]) / g[7] + 1;
            ow_n = (g[2] + 2 * g[6] - g[4]) / g[8] + 1;
        end while (g[0] * g[3] * g[4] * oh_n * ow_n > OUT_DEPTH);
        run_conv(g[0], g[1], g[2], g[3], g[4], g[5], g[6], g[7], g[8], rand_bits(8));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        logic [DATA_W-1:0] rd, exp_v;
        bus_resp_e         code;
        int                status_geo [10];
        lfsr       = 32'd70;
        stall_on   = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        resp_ready = 1'b0;
        rstnn      = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstnn = 1'b1;
        @(negedge clk);

        start_test("register readback");
        read_ok(REG_BASE + 4 * int'(RI_STATUS), rd);
        check_word(0, rd);                // Idle, no done
        for (int i = 0; i < 10; i++) begin
            exp_v = rand_bits(DATA_W);
            write_ok(REG_BASE + 4 * i, exp_v, 4'hF);
            read_ok(REG_BASE + 4 * i, rd);
            check_word(exp_v, rd);
        end
        write_ok(REG_BASE + 4 * int'(RI_PAD_W), 32'h1122_3344, 4'hF);
        write_ok(REG_BASE + 4 * int'(RI_PAD_W), 32'hAABB_CCDD, 4'b0101); // Bytes 0 and 2
        read_ok(REG_BASE + 4 * int'(RI_PAD_W), rd);
        check_word(32'h11BB_33DD, rd);
        end_test();

        start_test("decode errors");
        bus_xfer(1'b0, 'h2000, '0, '0, rd, code);
        check_resp(RESP_DECERR, code);
        check_word(0, rd);
        bus_xfer(1'b0, 'h1000, '0, '0, rd, code);     // Just past the input buffer
        check_resp(RESP_DECERR, code);
        check_word(0, rd);
        bus_xfer(1'b0, REG_BASE + 4 * REG_NUM, '0, '0, rd, code);
        check_resp(RESP_DECERR, code);
        check_word(0, rd);
        bus_xfer(1'b1, 'h8000, 32'h1, 4'hF, rd, code);
        check_resp(RESP_DECERR, code);
        bus_xfer(1'b1, OUT_BASE + 8, 32'h1, 4'hF, rd, code);
        check_resp(RESP_SLVERR, code);
        bus_xfer(1'b0, OUT_BASE + 8, '0, '0, rd, code);
        check_resp(RESP_OKAY, code);
        bus_xfer(1'b0, IN_BASE + 4, '0, '0, rd, code);  // Mapped, so no error
        check_resp(RESP_OKAY, code);
        bus_xfer(1'b1, IN_BASE + 4 * (IN_DEPTH - 1), 32'h5, 4'hF, rd, code);
        check_resp(RESP_OKAY, code);
        end_test();

        start_test("im2col no padding");
        run_conv(2, 5, 6, 3, 3, 0, 0, 1, 1, 0);
        end_test();

        start_test("padding stride zero point");
        run_conv(2, 7, 6, 3, 2, 2, 1, 2, 3, 32'h5A);
        end_test();

        stall_on = 1'b1;
        for (int n = 0; n < 5; n++) begin
            start_test($sformatf("random geometry %0d", n));
            random_conv();
            end_test();
        end
        stall_on = 1'b0;

        start_test("status sequencing");
        status_geo = '{1, 8, 8, 3, 3, 1, 1, 1, 1, 0};  // 576 elements, long enough to see busy
        work += 2 * 2 * 576 + 80;
        for (int i = 0; i < 10; i++) write_ok(REG_BASE + 4 * i, status_geo[i], 4'hF);
        repeat (2) begin
            write_ok(REG_BASE + 4 * int'(RI_CTRL), 1, 4'hF);
            read_ok(REG_BASE + 4 * int'(RI_STATUS), rd);
            check_word(1, rd);            // Busy, done cleared by start
            wait_done(rd);
            check_word(2, rd);            // Done, no longer busy
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* flist.f */
common/im2col_pkg.sv
src/im2col_buffer.sv
src/im2col_bus_slave.sv
src/im2col_regfile.sv
im2col_engine/im2col_engine.sv
src/im2col_top.sv
test/im2col_tb.sv

/* Makefile */
# Verilator build and run for the im2col testbench

VERILATOR ?= verilator
TOP       ?= im2col_tb
FLIST     ?= flist.f
VFLAGS    ?= --binary --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP FLIST VFLAGS OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
